// File: Makefile
# Verilator flow for the load/store unit

.PHONY: help test clean

BUILD := build

help:
	@echo "make test   build and run tb_lsu_top with Verilator"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_lsu_top \
		-f lsu_top.f --Mdir $(BUILD) -o tb_lsu_top
	@out=$$(./$(BUILD)/tb_lsu_top); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD)

// File: lsu_top.f
src/lsu_pkg.sv
src/lsu_agu.sv
src/lsu_mem_stage.sv
src/lsu_load_align.sv
src/lsu_top.sv
sim/lsu_properties.sv
sim/tb_lsu_top.sv

// File: sim/lsu_properties.sv
// ----------------------------------------------------------
// handshake and reset properties of the load/store unit
// ----------------------------------------------------------

`default_nettype none

module lsu_properties (
    input logic                           clk_i,
    input logic                           rst_ni,
    input logic                           req_ready_o,
    input logic                           resp_valid_o,
    input logic                           resp_ready_i,
    input logic [lsu_pkg::TRANS_ID_W-1:0] resp_trans_id_o,
    input logic [lsu_pkg::XLEN-1:0]       resp_rdata_o,
    input logic                           resp_exc_o,
    input lsu_pkg::exc_cause_e            resp_exc_cause_o,
    input logic [lsu_pkg::XLEN-1:0]       resp_exc_tval_o
);
    timeunit 1ns;
    timeprecision 1ps;

    resp_idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !resp_valid_o)
        else $error("resp_valid_o high during reset");

    // a stalled response keeps every field
    resp_stable_on_stall: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_trans_id_o)
            && $stable(resp_rdata_o) && $stable(resp_exc_o)
            && $stable(resp_exc_cause_o) && $stable(resp_exc_tval_o)
    ) else $error("response changed while stalled");

    ready_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> req_ready_o)
        else $error("req_ready_o low in the first cycle after reset");

endmodule

bind lsu_top lsu_properties i_props (.*);

`default_nettype wire

// File: sim/tb_lsu_top.sv
// ----------------------------------------------------------
// testbench for the load/store unit
// table-driven requests, reference memory model, random
// response back-pressure and a watchdog
// ----------------------------------------------------------

`default_nettype none

module tb_lsu_top;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    typedef struct packed {
        lsu_op_e         op;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] wdata;
        logic            exc;
        // response side held ready, latency checked
        logic            timed;
    } row_t;

    typedef struct packed {
        logic [TRANS_ID_W-1:0] id;
        logic [XLEN-1:0]       data;
        logic                  exc;
        exc_cause_e            cause;
        logic [XLEN-1:0]       tval;
        logic                  timed;
        int                    acc_cycle;
    } exp_t;

    localparam int NROWS = 34;

    // ----------------------------------------------------------
    // stimulus table: op, base, imm, wdata, exc, timed
    // ----------------------------------------------------------
    row_t rows [NROWS] = '{
        // word stores incl. negative imm and wrap above 255
        '{SW,  32'h0000_0000, 32'h0000_0010, 32'h1122_3344, 1'b0, 1'b1},
        '{SW,  32'h0000_0040, 32'hFFFF_FFFC, 32'hA5A5_5A5A, 1'b0, 1'b1},
        '{SW,  32'h0000_01F0, 32'h0000_0014, 32'h8070_F00F, 1'b0, 1'b1},
        '{SW,  32'h0000_0080, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0, 1'b1},
        '{LW,  32'h0000_0000, 32'h0000_0010, 32'h0000_0000, 1'b0, 1'b1},
        '{LW,  32'h0000_0100, 32'h0000_003C, 32'h0000_0000, 1'b0, 1'b1},
        '{LW,  32'h0000_0004, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1},
        '{LW,  32'h0000_0080, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1},
        // sub-word stores merge into the word
        '{SB,  32'h0000_0010, 32'h0000_0001, 32'h0000_00FF, 1'b0, 1'b0},
        '{SH,  32'h0000_0010, 32'h0000_0002, 32'h0000_BEEF, 1'b0, 1'b0},
        '{LW,  32'h0000_0010, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0},
        '{SW,  32'h0000_0020, 32'h0000_0000, 32'h7F01_4C3E, 1'b0, 1'b0},
        // sign and zero extension at every offset
        '{LB,  32'h0000_0080, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0},
        '{LB,  32'h0000_0080, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b0},
        '{LB,  32'h0000_0080, 32'h0000_0002, 32'h0000_0000, 1'b0, 1'b0},
        '{LB,  32'h0000_0080, 32'h0000_0003, 32'h0000_0000, 1'b0, 1'b0},
        '{LBU, 32'h0000_0080, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0},
        '{LBU, 32'h0000_0080, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b0},
        '{LBU, 32'h0000_0080, 32'h0000_0002, 32'h0000_0000, 1'b0, 1'b0},
        '{LBU, 32'h0000_0080, 32'h0000_0003, 32'h0000_0000, 1'b0, 1'b0},
        '{LB,  32'h0000_0020, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0},
        '{LB,  32'h0000_0020, 32'h0000_0001, 32'h0000_0000, 1'b0, 1'b0},
        '{LB,  32'h0000_0020, 32'h0000_0002, 32'h0000_0000, 1'b0, 1'b0},
        '{LB,  32'h0000_0020, 32'h0000_0003, 32'h0000_0000, 1'b0, 1'b0},
        '{LH,  32'h0000_0080, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0},
        '{LH,  32'h0000_0080, 32'h0000_0002, 32'h0000_0000, 1'b0, 1'b0},
        '{LHU, 32'h0000_0080, 32'h0000_0002, 32'h0000_0000, 1'b0, 1'b0},
        '{LH,  32'h0000_0020, 32'h0000_0002, 32'h0000_0000, 1'b0, 1'b0},
        '{LHU, 32'h0000_0020, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0},
        // misaligned accesses, then proof the store was dropped
        '{LH,  32'h0000_0020, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b0},
        '{LW,  32'h0000_0020, 32'h0000_0002, 32'h0000_0000, 1'b1, 1'b0},
        '{SH,  32'h0000_0020, 32'h0000_0003, 32'h0000_FFFF, 1'b1, 1'b0},
        '{SW,  32'h0000_1020, 32'h0000_0001, 32'hFFFF_FFFF, 1'b1, 1'b0},
        '{LW,  32'h0000_0020, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0}
    };

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req_valid;
    lsu_op_e               req_op;
    logic [XLEN-1:0]       req_base;
    logic [XLEN-1:0]       req_imm;
    logic [XLEN-1:0]       req_wdata;
    logic [TRANS_ID_W-1:0] req_id;
    logic                  req_ready;
    logic                  resp_valid;
    logic [TRANS_ID_W-1:0] resp_id;
    logic [XLEN-1:0]       resp_rdata;
    logic                  resp_exc;
    exc_cause_e            resp_cause;
    logic [XLEN-1:0]       resp_tval;
    logic                  resp_ready;

    logic [XLEN-1:0]       ref_mem [MEM_WORDS];
    exp_t                  exp_q [$];
    int                    errors    = 0;
    int                    resp_cnt  = 0;
    int                    cycle_cnt = 0;

    always #10 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    lsu_top i_dut (
        .clk_i            ( clk        ),
        .rst_ni           ( rst_n      ),
        .req_valid_i      ( req_valid  ),
        .req_op_i         ( req_op     ),
        .req_base_i       ( req_base   ),
        .req_imm_i        ( req_imm    ),
        .req_wdata_i      ( req_wdata  ),
        .req_trans_id_i   ( req_id     ),
        .req_ready_o      ( req_ready  ),
        .resp_valid_o     ( resp_valid ),
        .resp_trans_id_o  ( resp_id    ),
        .resp_rdata_o     ( resp_rdata ),
        .resp_exc_o       ( resp_exc   ),
        .resp_exc_cause_o ( resp_cause ),
        .resp_exc_tval_o  ( resp_tval  ),
        .resp_ready_i     ( resp_ready )
    );

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int access_bytes(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic is_write(lsu_op_e op);
        return op == SB || op == SH || op == SW;
    endfunction

    function automatic logic [XLEN-1:0] extend_load(lsu_op_e op, logic [XLEN-1:0] word,
                                                    int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        // halfwords only ever sit at offset 0 or 2
        h = word[8*(off & 2) +: 16];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            LW:      return word;
            default: return '0;
        endcase
    endfunction

    // update the memory copy and queue the response of one row
    task automatic model_row(input int idx, input int acc);
        row_t            r;
        exp_t            e;
        logic [XLEN-1:0] addr;
        int              off;
        int              w;
        r           = rows[idx];
        addr        = r.base + r.imm;
        off         = int'(addr[1:0]);
        w           = int'(addr[MEM_AW+1:2]);
        e.id        = TRANS_ID_W'(idx);
        e.exc       = r.exc;
        e.cause     = EXC_NONE;
        e.tval      = '0;
        e.data      = '0;
        e.timed     = r.timed;
        e.acc_cycle = acc;
        if (r.exc) begin
            e.cause = is_write(r.op) ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
            e.tval  = addr;
        end else if (is_write(r.op)) begin
            for (int k = 0; k < access_bytes(r.op); k++) begin
                ref_mem[w][8*(off+k) +: 8] = r.wdata[8*k +: 8];
            end
        end else begin
            e.data = extend_load(r.op, ref_mem[w], off);
        end
        exp_q.push_back(e);
    endtask

    task automatic compare_field(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] want);
        assert (got === want) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, want);
        end
    endtask

    // ----------------------------------------------------------
    // response monitor
    // ----------------------------------------------------------
    always @(posedge clk) begin : monitor
        exp_t e;
        if (rst_n && resp_valid && resp_ready) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("response id %0d arrived with no request outstanding", resp_id);
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                compare_field("resp_trans_id_o", XLEN'(resp_id), XLEN'(e.id));
                compare_field("resp_rdata_o", resp_rdata, e.data);
                compare_field("resp_exc_o", XLEN'(resp_exc), XLEN'(e.exc));
                compare_field("resp_exc_cause_o", XLEN'(resp_cause), XLEN'(e.cause));
                compare_field("resp_exc_tval_o", resp_tval, e.tval);
                // handshake lands three edges after acceptance
                if (e.timed) begin
                    assert (cycle_cnt - e.acc_cycle == 3) else begin
                        errors++;
                        $display("response id %0d took %0d cycles instead of 3",
                                 e.id, cycle_cnt - e.acc_cycle);
                    end
                end
            end
            resp_cnt++;
        end
    end

    // fully ready until the timed rows drain, then random stalls
    initial begin : ready_gen
        logic [15:0] lfsr;
        int          n_timed;
        logic        b0;
        logic        b1;
        lfsr       = 16'd51;
        n_timed    = 0;
        resp_ready = 1'b0;
        foreach (rows[i]) begin
            if (rows[i].timed) begin
                n_timed++;
            end
        end
        forever begin
            @(negedge clk);
            if (resp_cnt < n_timed) begin
                resp_ready = 1'b1;
            end else begin
                lfsr       = lfsr_next(lfsr);
                b0         = lfsr[0];
                lfsr       = lfsr_next(lfsr);
                b1         = lfsr[0];
                resp_ready = b0 | b1;
            end
        end
    end

    // ----------------------------------------------------------
    // request driver and end of test
    // ----------------------------------------------------------
    initial begin : driver
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = LW;
        req_base  = '0;
        req_imm   = '0;
        req_wdata = '0;
        req_id    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NROWS; i++) begin
            @(negedge clk);
            req_valid = 1'b1;
            req_op    = rows[i].op;
            req_base  = rows[i].base;
            req_imm   = rows[i].imm;
            req_wdata = rows[i].wdata;
            req_id    = TRANS_ID_W'(i);
            do begin
                @(posedge clk);
            end while (!req_ready);
            model_row(i, cycle_cnt);
        end
        @(negedge clk);
        req_valid = 1'b0;
        wait (resp_cnt == NROWS);
        // idle cycles catch late or duplicated responses
        repeat (5) @(posedge clk);
        $display("%0d errors in %0d responses", errors, resp_cnt);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NROWS * 40 + 200) @(posedge clk);
        $display("timeout, only %0d of %0d responses arrived", resp_cnt, NROWS);
        $display("%0d errors in %0d responses", errors, resp_cnt);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/lsu_agu.sv
// ----------------------------------------------------------
// address generation stage
// base plus immediate, byte enables, misalignment check,
// store data lane shift and the first pipeline register
// ----------------------------------------------------------

`default_nettype none

module lsu_agu (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           in_valid_i,
    input  lsu_pkg::lsu_op_e               op_i,
    input  logic [lsu_pkg::XLEN-1:0]       base_i,
    input  logic [lsu_pkg::XLEN-1:0]       imm_i,
    input  logic [lsu_pkg::XLEN-1:0]       wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0] trans_id_i,
    input  logic                           out_ready_i,
    output logic                           in_ready_o,
    output logic                           out_valid_o,
    output lsu_pkg::lsu_op_e               out_op_o,
    output logic [lsu_pkg::MEM_AW-1:0]     out_word_idx_o,
    output logic [1:0]                     out_byte_off_o,
    output logic [lsu_pkg::BE_W-1:0]       out_be_o,
    output logic [lsu_pkg::XLEN-1:0]       out_wdata_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0] out_trans_id_o,
    output logic                           out_misaligned_o,
    output logic [lsu_pkg::XLEN-1:0]       out_addr_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata_lanes;
    logic [BE_W-1:0] be;
    logic            misaligned;
    logic            valid_q;
    logic            xfer_in;

    // two's complement add, a negative immediate just wraps
    assign addr        = base_i + imm_i;
    assign wdata_lanes = wdata_i << {addr[1:0], 3'b000};

    // ----------------------------------------------------------
    // byte enables and alignment
    // ----------------------------------------------------------
    always_comb begin
        unique case (op_i)
            LB, LBU, SB: begin
                be         = BE_W'(1) << addr[1:0];
                misaligned = 1'b0;
            end
            LH, LHU, SH: begin
                be         = BE_W'(3) << addr[1:0];
                misaligned = addr[0];
            end
            default: begin
                // word access uses all lanes
                be         = '1;
                misaligned = |addr[1:0];
            end
        endcase
    end

    // ----------------------------------------------------------
    // first pipeline register
    // ----------------------------------------------------------
    assign in_ready_o  = !valid_q || out_ready_i;
    assign xfer_in     = in_valid_i && in_ready_o;
    assign out_valid_o = valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (xfer_in) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer_in) begin
            out_op_o         <= op_i;
            out_word_idx_o   <= addr[MEM_AW+1:2];
            out_byte_off_o   <= addr[1:0];
            out_be_o         <= be;
            out_wdata_o      <= wdata_lanes;
            out_trans_id_o   <= trans_id_i;
            out_misaligned_o <= misaligned;
            out_addr_o       <= addr;
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_load_align.sv
// ----------------------------------------------------------
// load align stage
// extracts and extends load data, formats misalignment
// exceptions and holds the response register
// ----------------------------------------------------------

`default_nettype none

module lsu_load_align (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           in_valid_i,
    input  lsu_pkg::lsu_op_e               in_op_i,
    input  logic [1:0]                     in_byte_off_i,
    input  logic [lsu_pkg::XLEN-1:0]       in_rdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0] in_trans_id_i,
    input  logic                           in_misaligned_i,
    input  logic [lsu_pkg::XLEN-1:0]       in_addr_i,
    input  logic                           out_ready_i,
    output logic                           in_ready_o,
    output logic                           out_valid_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0] out_trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]       out_rdata_o,
    output logic                           out_exc_o,
    output lsu_pkg::exc_cause_e            out_exc_cause_o,
    output logic [lsu_pkg::XLEN-1:0]       out_exc_tval_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] rdata_d;
    logic [XLEN-1:0] tval_d;
    exc_cause_e      cause_d;
    logic            valid_q;
    logic            xfer_in;

    // bring the addressed byte or halfword down to lane 0
    assign shifted = in_rdata_i >> {in_byte_off_i, 3'b000};

    // ----------------------------------------------------------
    // data extension and exception format
    // ----------------------------------------------------------
    always_comb begin
        rdata_d = '0;
        cause_d = EXC_NONE;
        tval_d  = '0;
        if (in_misaligned_i) begin
            cause_d = op_is_store(in_op_i) ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
            tval_d  = in_addr_i;
        end else begin
            unique case (in_op_i)
                LB:      rdata_d = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
                LBU:     rdata_d = {{(XLEN-8){1'b0}}, shifted[7:0]};
                LH:      rdata_d = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
                LHU:     rdata_d = {{(XLEN-16){1'b0}}, shifted[15:0]};
                LW:      rdata_d = in_rdata_i;
                // stores answer with zero
                default: rdata_d = '0;
            endcase
        end
    end

    // ----------------------------------------------------------
    // response register
    // ----------------------------------------------------------
    assign in_ready_o  = !valid_q || out_ready_i;
    assign xfer_in     = in_valid_i && in_ready_o;
    assign out_valid_o = valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (xfer_in) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // fields only change on a transfer in, so a stall holds them
    always_ff @(posedge clk_i) begin
        if (xfer_in) begin
            out_trans_id_o  <= in_trans_id_i;
            out_rdata_o     <= rdata_d;
            out_exc_o       <= in_misaligned_i;
            out_exc_cause_o <= cause_d;
            out_exc_tval_o  <= tval_d;
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_mem_stage.sv
// ----------------------------------------------------------
// memory stage
// 64-word data memory with byte-enabled writes and a
// synchronous read, plus the second pipeline register
// ----------------------------------------------------------

`default_nettype none

module lsu_mem_stage (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           in_valid_i,
    input  lsu_pkg::lsu_op_e               in_op_i,
    input  logic [lsu_pkg::MEM_AW-1:0]     in_word_idx_i,
    input  logic [1:0]                     in_byte_off_i,
    input  logic [lsu_pkg::BE_W-1:0]       in_be_i,
    input  logic [lsu_pkg::XLEN-1:0]       in_wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0] in_trans_id_i,
    input  logic                           in_misaligned_i,
    input  logic [lsu_pkg::XLEN-1:0]       in_addr_i,
    input  logic                           out_ready_i,
    output logic                           in_ready_o,
    output logic                           out_valid_o,
    output lsu_pkg::lsu_op_e               out_op_o,
    output logic [1:0]                     out_byte_off_o,
    output logic [lsu_pkg::XLEN-1:0]       out_rdata_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0] out_trans_id_o,
    output logic                           out_misaligned_o,
    output logic [lsu_pkg::XLEN-1:0]       out_addr_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] mem_q [MEM_WORDS];
    logic            valid_q;
    logic            xfer_in;
    logic            wr_en;

    assign in_ready_o  = !valid_q || out_ready_i;
    assign xfer_in     = in_valid_i && in_ready_o;
    assign out_valid_o = valid_q;

    // misaligned stores are dropped here
    assign wr_en = xfer_in && op_is_store(in_op_i) && !in_misaligned_i;

    // ----------------------------------------------------------
    // data memory
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int i = 0; i < BE_W; i++) begin
                if (in_be_i[i]) begin
                    mem_q[in_word_idx_i][8*i +: 8] <= in_wdata_i[8*i +: 8];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // second pipeline register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (xfer_in) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // read sees every store written on an earlier edge
    always_ff @(posedge clk_i) begin
        if (xfer_in) begin
            out_op_o         <= in_op_i;
            out_byte_off_o   <= in_byte_off_i;
            out_rdata_o      <= mem_q[in_word_idx_i];
            out_trans_id_o   <= in_trans_id_i;
            out_misaligned_o <= in_misaligned_i;
            out_addr_o       <= in_addr_i;
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
// ----------------------------------------------------------
// load/store unit package
// widths, data memory geometry, operation and exception
// cause encodings shared by all pipeline stages
// ----------------------------------------------------------

`default_nettype none

package lsu_pkg;

    // ----------------------------------------------------------
    // widths and memory geometry
    // ----------------------------------------------------------
    localparam int unsigned XLEN        = 32;
    localparam int unsigned TRANS_ID_W  = 3;
    localparam int unsigned MEM_WORDS   = 64;
    // word index taken from address bits 7..2
    localparam int unsigned MEM_AW      = 6;
    localparam int unsigned BE_W        = XLEN / 8;
    localparam int unsigned EXC_CAUSE_W = 5;

    // ----------------------------------------------------------
    // operations
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } lsu_op_e;

    // riscv mcause values for address misalignment
    typedef enum logic [EXC_CAUSE_W-1:0] {
        EXC_NONE           = 5'd0,
        LD_ADDR_MISALIGNED = 5'd4,
        ST_ADDR_MISALIGNED = 5'd6
    } exc_cause_e;

    // stores write memory, everything else reads
    function automatic logic op_is_store(lsu_op_e op);
        return op inside {SB, SH, SW};
    endfunction

endpackage

`default_nettype wire

// File: src/lsu_top.sv
// ----------------------------------------------------------
// load/store unit top level
// agu, memory and load align stages chained by valid/ready
// ----------------------------------------------------------

`default_nettype none

module lsu_top (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           req_valid_i,
    input  lsu_pkg::lsu_op_e               req_op_i,
    input  logic [lsu_pkg::XLEN-1:0]       req_base_i,
    input  logic [lsu_pkg::XLEN-1:0]       req_imm_i,
    input  logic [lsu_pkg::XLEN-1:0]       req_wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0] req_trans_id_i,
    output logic                           req_ready_o,
    output logic                           resp_valid_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0] resp_trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]       resp_rdata_o,
    output logic                           resp_exc_o,
    output lsu_pkg::exc_cause_e            resp_exc_cause_o,
    output logic [lsu_pkg::XLEN-1:0]       resp_exc_tval_o,
    input  logic                           resp_ready_i
);
    import lsu_pkg::*;

    // agu to memory stage
    logic                  agu_valid;
    logic                  agu_ready;
    lsu_op_e               agu_op;
    logic [MEM_AW-1:0]     agu_word_idx;
    logic [1:0]            agu_byte_off;
    logic [BE_W-1:0]       agu_be;
    logic [XLEN-1:0]       agu_wdata;
    logic [TRANS_ID_W-1:0] agu_trans_id;
    logic                  agu_misaligned;
    logic [XLEN-1:0]       agu_addr;

    // memory stage to load align
    logic                  mem_valid;
    logic                  mem_ready;
    lsu_op_e               mem_op;
    logic [1:0]            mem_byte_off;
    logic [XLEN-1:0]       mem_rdata;
    logic [TRANS_ID_W-1:0] mem_trans_id;
    logic                  mem_misaligned;
    logic [XLEN-1:0]       mem_addr;

    lsu_agu i_agu (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_ni         ),
        .in_valid_i       ( req_valid_i    ),
        .op_i             ( req_op_i       ),
        .base_i           ( req_base_i     ),
        .imm_i            ( req_imm_i      ),
        .wdata_i          ( req_wdata_i    ),
        .trans_id_i       ( req_trans_id_i ),
        .out_ready_i      ( agu_ready      ),
        .in_ready_o       ( req_ready_o    ),
        .out_valid_o      ( agu_valid      ),
        .out_op_o         ( agu_op         ),
        .out_word_idx_o   ( agu_word_idx   ),
        .out_byte_off_o   ( agu_byte_off   ),
        .out_be_o         ( agu_be         ),
        .out_wdata_o      ( agu_wdata      ),
        .out_trans_id_o   ( agu_trans_id   ),
        .out_misaligned_o ( agu_misaligned ),
        .out_addr_o       ( agu_addr       )
    );

    lsu_mem_stage i_mem_stage (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_ni         ),
        .in_valid_i       ( agu_valid      ),
        .in_op_i          ( agu_op         ),
        .in_word_idx_i    ( agu_word_idx   ),
        .in_byte_off_i    ( agu_byte_off   ),
        .in_be_i          ( agu_be         ),
        .in_wdata_i       ( agu_wdata      ),
        .in_trans_id_i    ( agu_trans_id   ),
        .in_misaligned_i  ( agu_misaligned ),
        .in_addr_i        ( agu_addr       ),
        .out_ready_i      ( mem_ready      ),
        .in_ready_o       ( agu_ready      ),
        .out_valid_o      ( mem_valid      ),
        .out_op_o         ( mem_op         ),
        .out_byte_off_o   ( mem_byte_off   ),
        .out_rdata_o      ( mem_rdata      ),
        .out_trans_id_o   ( mem_trans_id   ),
        .out_misaligned_o ( mem_misaligned ),
        .out_addr_o       ( mem_addr       )
    );

    lsu_load_align i_load_align (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .in_valid_i       ( mem_valid        ),
        .in_op_i          ( mem_op           ),
        .in_byte_off_i    ( mem_byte_off     ),
        .in_rdata_i       ( mem_rdata        ),
        .in_trans_id_i    ( mem_trans_id     ),
        .in_misaligned_i  ( mem_misaligned   ),
        .in_addr_i        ( mem_addr         ),
        .out_ready_i      ( resp_ready_i     ),
        .in_ready_o       ( mem_ready        ),
        .out_valid_o      ( resp_valid_o     ),
        .out_trans_id_o   ( resp_trans_id_o  ),
        .out_rdata_o      ( resp_rdata_o     ),
        .out_exc_o        ( resp_exc_o       ),
        .out_exc_cause_o  ( resp_exc_cause_o ),
        .out_exc_tval_o   ( resp_exc_tval_o  )
    );

endmodule

`default_nettype wire
